// File: pcl_stim.txt
// 48-bit hex words. Word 0 is the point count, then one point per word as zzzz yyyy xxxx
// Then the run count, then per run a header (mode nip nop k, one byte each, 16-bit count)
// followed by the expected indices, six per word, first index in the top byte
000000000008
000000000000 // p0 (0,0,0)
000000000001 // p1 (1,0,0)
000000020000 // p2 (0,2,0)
000000000003 // p3 (3,0,0)
000400000000 // p4 (0,0,4)
000000050005 // p5 (5,5,0)
000100010001 // p6 (1,1,1)
000200020002 // p7 (2,2,2)
000000000004
// KNN, 8 points, K=3, ties at center 6 go to the lower index
010700030018
000106010006
020600030106
040607050703
060100070602
// KNN, 4 points, K=6, each center gives all 4
010300060010
000102030100
030202000103
030100020000
// FPS, 8 points, 4 outputs
000703010004
000504070000
// FPS again, 6 outputs, stale distance words from the last run
000705010006
000504070302

// File: flist.f
pcl_geom_pkg.sv
pcl_ctrl_pkg.sv
glb_sram.sv
glb_arb.sv
pcl_ctr.sv
knn_sort.sv
pcl_top.sv
tb_pcl_assert.sv
tb_pcl.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_pcl -f flist.f -o sim_pcl \
    || { echo "Build failed"; exit 1; }
./obj_dir/sim_pcl > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Result: fail"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Result: run did not complete"; exit 1; }
echo "Result: pass"

// File: tb_pcl.sv
// Point cloud engine testbench
`timescale 1ns/1ps

module tb_pcl;

    localparam int STIM_WORDS = 64;
    localparam int WAIT_LIMIT = 2000;
    localparam int RUN_LIMIT = 40000;

    logic clk;
    logic rst_n;
    logic host_req;
    pcl_ctrl_pkg::addr_t host_addr;
    logic [pcl_ctrl_pkg::MEM_WIDTH-1:0] host_wdata;
    logic host_gnt;
    logic cfg_vld;
    logic cfg_rdy;
    logic cfg_mode;
    pcl_ctrl_pkg::idx_t cfg_nip;
    pcl_ctrl_pkg::idx_t cfg_nop;
    pcl_ctrl_pkg::k_t cfg_k;
    logic out_vld;
    logic out_last;
    logic out_rdy;
    pcl_ctrl_pkg::idx_t out_idx;

    // Stim image, see pcl_stim.txt for the layout
    logic [pcl_ctrl_pkg::MEM_WIDTH-1:0] stim [STIM_WORDS];
    int errors;
    int test_errs;
    int tests_run;
    int tests_failed;
    int gnt_seen;
    int ptr;
    int ncfg;
    bit aborted;

    pcl_top DUT (
        .clk(clk), .rst_n(rst_n),
        .host_req(host_req), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_gnt(host_gnt),
        .cfg_vld(cfg_vld), .cfg_rdy(cfg_rdy), .cfg_mode(cfg_mode),
        .cfg_nip(cfg_nip), .cfg_nop(cfg_nop), .cfg_k(cfg_k),
        .out_vld(out_vld), .out_idx(out_idx), .out_last(out_last), .out_rdy(out_rdy)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Host grants seen on the port
    always @(posedge clk) begin
        if (!rst_n) begin
            gnt_seen <= 0;
        end else if (host_gnt) begin
            gnt_seen <= gnt_seen + 1;
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================
    // Sink ready about three cycles in four
    function automatic logic pick_ready();
        return ($urandom % 4) != 0;
    endfunction

    task automatic check_val(input string name, input string what, input int exp,
                             input int act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %0d, actual %0d", name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, test_errs);
        end
        errors += test_errs;
        test_errs = 0;
    endtask

    // One write per point, next request right after each grant
    task automatic load_points(input string name);
        int npts;
        int waited;
        npts = int'(stim[0]);
        for (int p = 0; p < npts; p++) begin
            host_req <= 1'b1;
            host_addr <= pcl_ctrl_pkg::addr_t'(p);
            host_wdata <= stim[1 + p];
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!host_gnt && waited < WAIT_LIMIT);
            assert (host_gnt) else begin
                $display("Timeout in %s, point %0d was never granted", name, p);
                test_errs++;
                aborted = 1'b1;
            end
            if (aborted) begin
                break;
            end
        end
        host_req <= 1'b0;
        @(posedge clk);
        check_val(name, "host grants", npts, gnt_seen);
    endtask

    // ==================================================================
    // One configuration and its index stream
    // ==================================================================
    task automatic run_config(input int c, input int base);
        logic [pcl_ctrl_pkg::MEM_WIDTH-1:0] hdr;
        string name;
        int count;
        int got;
        int waited;
        int expv;
        hdr = stim[base];
        count = int'(hdr[15:0]);
        name = $sformatf("cfg%0d_%s_k%0d", c, hdr[40] ? "knn" : "fps", int'(hdr[19:16]));
        // Fields stay put until the next run
        cfg_mode <= hdr[40];
        cfg_nip <= hdr[37:32];
        cfg_nop <= hdr[29:24];
        cfg_k <= hdr[19:16];
        cfg_vld <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            out_rdy <= pick_ready();
            waited++;
        end while (!cfg_rdy && waited < WAIT_LIMIT);
        cfg_vld <= 1'b0;
        assert (cfg_rdy) else begin
            $display("Timeout in %s, configuration was not accepted", name);
            test_errs++;
            aborted = 1'b1;
        end
        got = 0;
        waited = 0;
        while (!aborted && got < count && waited < RUN_LIMIT) begin
            @(posedge clk);
            waited++;
            // Not ready for a new run before the last beat
            check_val(name, $sformatf("cfg_rdy before beat %0d", got), 0, int'(cfg_rdy));
            if (out_vld && out_rdy) begin
                // Six indices per word, first in the top byte
                expv = int'(stim[base + 1 + got / 6][(5 - got % 6) * 8 +: 8]);
                check_val(name, $sformatf("beat %0d index", got), expv, int'(out_idx));
                check_val(name, $sformatf("beat %0d last", got),
                          (got == count - 1) ? 1 : 0, int'(out_last));
                got++;
            end
            out_rdy <= pick_ready();
        end
        assert (aborted || got == count) else begin
            $display("Timeout in %s, %0d of %0d indices arrived", name, got, count);
            test_errs++;
            aborted = 1'b1;
        end
        waited = 0;
        while (!aborted && !cfg_rdy && waited < WAIT_LIMIT) begin
            @(posedge clk);
            out_rdy <= pick_ready();
            waited++;
        end
        if (!aborted) begin
            check_val(name, "cycles from last beat to cfg_rdy", 1, waited);
            check_val(name, "out_vld after run", 0, int'(out_vld));
        end
        end_test(name);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        void'($urandom(32'h502f));
        rst_n = 1'b0;
        host_req = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        cfg_vld = 1'b0;
        cfg_mode = 1'b0;
        cfg_nip = '0;
        cfg_nop = '0;
        cfg_k = '0;
        out_rdy = 1'b0;
        errors = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        aborted = 1'b0;
        $readmemh("pcl_stim.txt", stim);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val("reset_load", "cfg_rdy", 1, int'(cfg_rdy));
        check_val("reset_load", "out_vld", 0, int'(out_vld));
        load_points("reset_load");
        end_test("reset_load");
        // Runs follow the point set
        ptr = int'(stim[0]) + 1;
        ncfg = int'(stim[ptr]);
        ptr++;
        for (int c = 0; c < ncfg; c++) begin
            if (!aborted) begin
                run_config(c, ptr);
            end
            ptr = ptr + 1 + (int'(stim[ptr][15:0]) + 5) / 6;
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (tests_failed == 0 && !aborted) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb_pcl_assert.sv
// Arbiter and sorter handshake checks
`timescale 1ns/1ps

module tb_pcl_assert (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [pcl_ctrl_pkg::NUM_REQ-1:0]   req,
    input  logic [pcl_ctrl_pkg::NUM_REQ-1:0]   gnt,
    input  logic                               ent_vld,
    input  logic                               ent_rdy,
    input  pcl_ctrl_pkg::idx_t                 ent_idx,
    input  pcl_geom_pkg::dist_t                ent_dist,
    input  logic                               out_vld,
    input  logic                               out_rdy,
    input  pcl_ctrl_pkg::idx_t                 out_idx
);

    // ==================================================================
    // Buffer arbitration
    // ==================================================================
    // One buffer access per cycle
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
        else $error("more than one grant in a cycle");

    // Pending requests stay up until granted
    assert property (@(posedge clk) disable iff (!rst_n)
        (req & $past(req & ~gnt)) == $past(req & ~gnt))
        else $error("request dropped before its grant");

    // ==================================================================
    // Sorter handshakes
    // ==================================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_idx)))
        else $error("output index moved while stalled");

    // Entry held steady while the sorter is busy
    assert property (@(posedge clk) disable iff (!rst_n)
        (ent_vld && !ent_rdy) |=> (ent_vld && $stable(ent_idx) && $stable(ent_dist)))
        else $error("sorter entry changed while not ready");

endmodule

bind glb_arb tb_pcl_assert arb_chk (
    .clk(clk), .rst_n(rst_n), .req(req), .gnt(gnt),
    .ent_vld(1'b0), .ent_rdy(1'b1), .ent_idx('0), .ent_dist('0),
    .out_vld(1'b0), .out_rdy(1'b1), .out_idx('0)
);

bind knn_sort tb_pcl_assert sort_chk (
    .clk(clk), .rst_n(rst_n), .req('0), .gnt('0),
    .ent_vld(ent_vld), .ent_rdy(ent_rdy), .ent_idx(ent_idx), .ent_dist(ent_dist),
    .out_vld(out_vld), .out_rdy(out_rdy), .out_idx(out_idx)
);

// File: pcl_top.sv
// Point cloud engine top level
`timescale 1ns/1ps

module pcl_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Host load, write only
    input  logic                                 host_req,
    input  pcl_ctrl_pkg::addr_t                  host_addr,
    input  logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   host_wdata,
    output logic                                 host_gnt,
    // Configuration
    input  logic                                 cfg_vld,
    output logic                                 cfg_rdy,
    input  logic                                 cfg_mode,
    input  pcl_ctrl_pkg::idx_t                   cfg_nip,
    input  pcl_ctrl_pkg::idx_t                   cfg_nop,
    input  pcl_ctrl_pkg::k_t                     cfg_k,
    // Index stream
    output logic                                 out_vld,
    output pcl_ctrl_pkg::idx_t                   out_idx,
    output logic                                 out_last,
    input  logic                                 out_rdy
);

    logic [pcl_ctrl_pkg::NUM_REQ-1:0] gnt, rvalid;
    logic mem_en, mem_we;
    pcl_ctrl_pkg::addr_t mem_addr, crd_addr, dist_addr;
    logic [pcl_ctrl_pkg::MEM_WIDTH-1:0] mem_wdata, rdata, dist_wdata;
    logic crd_req, dist_req, dist_we;
    logic ent_vld, ent_flush, ent_flush_final, ent_rdy;
    pcl_geom_pkg::dist_t ent_dist;
    pcl_ctrl_pkg::idx_t ent_idx;

    assign host_gnt = gnt[pcl_ctrl_pkg::REQ_HOST];

    // ==================================================================
    // Buffer and arbiter
    // ==================================================================
    glb_sram u_sram (
        .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(rdata)
    );

    // Order host, coordinate, distance
    glb_arb u_arb (
        .clk(clk), .rst_n(rst_n),
        .req({dist_req, crd_req, host_req}), .we({dist_we, 1'b0, 1'b1}),
        .gnt(gnt), .rvalid(rvalid),
        .addr_host(host_addr), .addr_crd(crd_addr), .addr_dist(dist_addr),
        .wdata_host(host_wdata), .wdata_dist(dist_wdata),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    // ==================================================================
    // Controller and sorter
    // ==================================================================
    pcl_ctr u_ctr (
        .clk(clk), .rst_n(rst_n),
        .cfg_vld(cfg_vld), .cfg_rdy(cfg_rdy), .cfg_mode(cfg_mode),
        .cfg_nip(cfg_nip), .cfg_nop(cfg_nop),
        .crd_req(crd_req), .crd_addr(crd_addr),
        .crd_gnt(gnt[pcl_ctrl_pkg::REQ_CRD]), .crd_rvalid(rvalid[pcl_ctrl_pkg::REQ_CRD]),
        .dist_req(dist_req), .dist_we(dist_we), .dist_addr(dist_addr),
        .dist_wdata(dist_wdata), .dist_gnt(gnt[pcl_ctrl_pkg::REQ_DIST]),
        .dist_rvalid(rvalid[pcl_ctrl_pkg::REQ_DIST]), .rdata(rdata),
        .ent_vld(ent_vld), .ent_dist(ent_dist), .ent_idx(ent_idx),
        .ent_flush(ent_flush), .ent_flush_final(ent_flush_final), .ent_rdy(ent_rdy)
    );

    knn_sort u_sort (
        .clk(clk), .rst_n(rst_n), .cfg_k(cfg_k),
        .ent_vld(ent_vld), .ent_dist(ent_dist), .ent_idx(ent_idx),
        .ent_flush(ent_flush), .ent_flush_final(ent_flush_final), .ent_rdy(ent_rdy),
        .out_vld(out_vld), .out_idx(out_idx), .out_last(out_last), .out_rdy(out_rdy)
    );

endmodule

// File: knn_sort.sv
// Top-K insertion sorter
`timescale 1ns/1ps

module knn_sort (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pcl_ctrl_pkg::k_t       cfg_k,
    input  logic                   ent_vld,
    input  pcl_geom_pkg::dist_t    ent_dist,
    input  pcl_ctrl_pkg::idx_t     ent_idx,
    input  logic                   ent_flush,
    input  logic                   ent_flush_final,
    output logic                   ent_rdy,
    output logic                   out_vld,
    output pcl_ctrl_pkg::idx_t     out_idx,
    output logic                   out_last,
    input  logic                   out_rdy
);

    // Ascending list, slot 0 nearest
    pcl_geom_pkg::dist_t lst_d [pcl_ctrl_pkg::MAX_K];
    pcl_ctrl_pkg::idx_t lst_i [pcl_ctrl_pkg::MAX_K];
    pcl_ctrl_pkg::k_t cnt, base, pos, len, ocnt, olen;
    logic emitting, final_q, beat_last, grp_done, take;

    // ==================================================================
    // Output stream
    // ==================================================================
    assign out_vld = emitting;
    assign out_idx = lst_i[ocnt[2:0]];
    assign beat_last = ocnt == olen - 1'b1;
    assign grp_done = emitting & out_rdy & beat_last;
    assign out_last = emitting & final_q & beat_last;
    // Reopen in the same cycle as the closing beat
    assign ent_rdy = ~emitting | grp_done;
    assign take = ent_vld & ent_rdy;

    // List counts as empty once its group is out
    assign base = grp_done ? '0 : cnt;
    assign len = (cfg_k < base) ? cfg_k : base;

    // Insert behind equal distances
    always_comb begin
        pos = '0;
        for (int i = 0; i < pcl_ctrl_pkg::MAX_K; i++) begin
            if (pcl_ctrl_pkg::k_t'(i) < base && lst_d[i] <= ent_dist) begin
                pos = pos + 1'b1;
            end
        end
    end

    // ==================================================================
    // Count and emit control
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
            ocnt <= '0;
            olen <= '0;
            emitting <= 1'b0;
            final_q <= 1'b0;
        end else begin
            if (take) begin
                // Saturates, the tail falls off
                cnt <= (base == pcl_ctrl_pkg::MAX_K) ? base : base + 1'b1;
            end else if (grp_done) begin
                cnt <= '0;
            end
            if (ent_flush && ent_rdy) begin
                emitting <= len != '0;
                ocnt <= '0;
                olen <= len;
                final_q <= ent_flush_final;
            end else if (emitting && out_rdy) begin
                if (beat_last) begin
                    emitting <= 1'b0;
                end else begin
                    ocnt <= ocnt + 1'b1;
                end
            end
        end
    end

    // Shift the larger entries down one slot
    always_ff @(posedge clk) begin
        if (take) begin
            for (int i = 1; i < pcl_ctrl_pkg::MAX_K; i++) begin
                if (pcl_ctrl_pkg::k_t'(i) > pos) begin
                    lst_d[i] <= lst_d[i-1];
                    lst_i[i] <= lst_i[i-1];
                end
            end
            if (pos < pcl_ctrl_pkg::MAX_K) begin
                lst_d[pos[2:0]] <= ent_dist;
                lst_i[pos[2:0]] <= ent_idx;
            end
        end
    end

endmodule

// File: pcl_ctr.sv
// Sampling and grouping controller
`timescale 1ns/1ps

module pcl_ctr (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Configuration
    input  logic                                 cfg_vld,
    output logic                                 cfg_rdy,
    input  logic                                 cfg_mode,
    input  pcl_ctrl_pkg::idx_t                   cfg_nip,
    input  pcl_ctrl_pkg::idx_t                   cfg_nop,
    // Coordinate read port
    output logic                                 crd_req,
    output pcl_ctrl_pkg::addr_t                  crd_addr,
    input  logic                                 crd_gnt,
    input  logic                                 crd_rvalid,
    // Distance read and write-back port
    output logic                                 dist_req,
    output logic                                 dist_we,
    output pcl_ctrl_pkg::addr_t                  dist_addr,
    output logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   dist_wdata,
    input  logic                                 dist_gnt,
    input  logic                                 dist_rvalid,
    input  logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   rdata,
    // Sorter feed
    output logic                                 ent_vld,
    output pcl_geom_pkg::dist_t                  ent_dist,
    output pcl_ctrl_pkg::idx_t                   ent_idx,
    output logic                                 ent_flush,
    output logic                                 ent_flush_final,
    input  logic                                 ent_rdy
);

    pcl_ctrl_pkg::ctr_state_t state;
    pcl_ctrl_pkg::idx_t ctr_idx, pt_idx, out_cnt, max_idx;
    pcl_geom_pkg::crd_t ctr_crd;
    pcl_geom_pkg::dist_t sq, old, max_dist, opnd, new_min;
    // Per-point handshake progress
    logic c_req, c_wait, d_req, d_wait, sq_vld;
    logic first, emit_sent, in_loop, busy, proc_rdy, proc_done, last_grp;

    function automatic pcl_geom_pkg::dist_t sq_dist(input pcl_geom_pkg::crd_t a,
                                                    input pcl_geom_pkg::crd_t b);
        logic [pcl_geom_pkg::CRD_WIDTH-1:0] ca, cb, df;
        pcl_geom_pkg::dist_t acc;
        acc = '0;
        for (int d = 0; d < pcl_geom_pkg::CRD_DIM; d++) begin
            ca = a[d*pcl_geom_pkg::CRD_WIDTH +: pcl_geom_pkg::CRD_WIDTH];
            cb = b[d*pcl_geom_pkg::CRD_WIDTH +: pcl_geom_pkg::CRD_WIDTH];
            // Unsigned absolute difference
            df = (ca > cb) ? ca - cb : cb - ca;
            acc = acc + pcl_geom_pkg::dist_t'(df) * pcl_geom_pkg::dist_t'(df);
        end
        return acc;
    endfunction

    // ==================================================================
    // Datapath and port drive
    // ==================================================================
    assign cfg_rdy = state == pcl_ctrl_pkg::IDLE;
    assign in_loop = (state == pcl_ctrl_pkg::LOOP) || (state == pcl_ctrl_pkg::DRAIN);
    assign busy = c_req | c_wait | d_req | d_wait | sq_vld;
    // Point ready once its stored distance is back too
    assign proc_rdy = in_loop & sq_vld & ~d_req & ~d_wait;
    // First FPS pass ignores whatever the buffer holds
    assign opnd = first ? pcl_geom_pkg::DIST_MAX : old;
    assign new_min = (sq < opnd) ? sq : opnd;
    assign proc_done = proc_rdy & (cfg_mode ? ent_rdy : dist_gnt);
    assign last_grp = cfg_mode ? (ctr_idx == cfg_nip) : (out_cnt == cfg_nop);

    assign crd_req = c_req;
    assign crd_addr = (state == pcl_ctrl_pkg::CENTER) ? pcl_ctrl_pkg::addr_t'(ctr_idx)
                                                      : pcl_ctrl_pkg::addr_t'(pt_idx);
    // Same address for the read and the write-back
    assign dist_req = d_req | (proc_rdy & ~cfg_mode);
    assign dist_we = ~d_req;
    assign dist_addr = pcl_ctrl_pkg::DIST_BASE + pcl_ctrl_pkg::addr_t'(pt_idx);
    assign dist_wdata = {{(pcl_ctrl_pkg::MEM_WIDTH - pcl_geom_pkg::DIST_WIDTH){1'b0}}, new_min};

    // KNN entries from the loop, FPS pick from EMIT
    assign ent_vld = (proc_rdy & cfg_mode) |
                     ((state == pcl_ctrl_pkg::EMIT) & ~cfg_mode & ~emit_sent);
    assign ent_dist = in_loop ? sq : max_dist;
    assign ent_idx = in_loop ? pt_idx : max_idx;
    assign ent_flush = (state == pcl_ctrl_pkg::EMIT) & (cfg_mode | emit_sent);
    assign ent_flush_final = ent_flush & last_grp;

    // ==================================================================
    // FSM and loop control
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pcl_ctrl_pkg::IDLE;
            {c_req, c_wait, d_req, d_wait, sq_vld, first, emit_sent} <= '0;
            {ctr_idx, pt_idx, out_cnt, max_idx} <= '0;
            max_dist <= '0;
        end else begin
            // Read handshakes
            if (crd_gnt) begin
                c_req <= 1'b0;
                c_wait <= 1'b1;
            end
            if (crd_rvalid) begin
                c_wait <= 1'b0;
                sq_vld <= in_loop;
            end
            if (dist_gnt && d_req) begin
                d_req <= 1'b0;
                d_wait <= 1'b1;
            end
            if (dist_rvalid) begin
                d_wait <= 1'b0;
            end
            if (proc_done) begin
                sq_vld <= 1'b0;
                pt_idx <= pt_idx + 1'b1;
                // Strict test keeps the lowest index on ties
                if (!cfg_mode && new_min > max_dist) begin
                    max_dist <= new_min;
                    max_idx <= pt_idx;
                end
            end
            case (state)
                pcl_ctrl_pkg::IDLE: if (cfg_vld) begin
                    {ctr_idx, out_cnt, max_idx} <= '0;
                    max_dist <= '0;
                    first <= 1'b1;
                    // FPS starts by sending point 0
                    c_req <= cfg_mode;
                    state <= cfg_mode ? pcl_ctrl_pkg::CENTER : pcl_ctrl_pkg::EMIT;
                end
                pcl_ctrl_pkg::CENTER: if (crd_rvalid) begin
                    {pt_idx, max_idx} <= '0;
                    max_dist <= '0;
                    state <= pcl_ctrl_pkg::LOOP;
                end
                // One point in flight at a time
                pcl_ctrl_pkg::LOOP: if (!busy) begin
                    c_req <= 1'b1;
                    d_req <= ~cfg_mode & ~first;
                    if (pt_idx == cfg_nip) begin
                        state <= pcl_ctrl_pkg::DRAIN;
                    end
                end
                pcl_ctrl_pkg::DRAIN: if (!busy) begin
                    first <= 1'b0;
                    state <= pcl_ctrl_pkg::EMIT;
                end
                pcl_ctrl_pkg::EMIT: begin
                    if (ent_vld && ent_rdy) begin
                        emit_sent <= 1'b1;
                    end
                    if (ent_flush && ent_rdy) begin
                        emit_sent <= 1'b0;
                        if (last_grp) begin
                            state <= pcl_ctrl_pkg::FINISH;
                        end else begin
                            // Next center, the new FPS pick becomes it
                            c_req <= 1'b1;
                            ctr_idx <= cfg_mode ? ctr_idx + 1'b1 : max_idx;
                            out_cnt <= out_cnt + {5'd0, ~cfg_mode};
                            state <= pcl_ctrl_pkg::CENTER;
                        end
                    end
                end
                // Sorter ready again once the last beat goes out
                pcl_ctrl_pkg::FINISH: if (ent_rdy) begin
                    state <= pcl_ctrl_pkg::IDLE;
                end
                default: state <= pcl_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Center coordinate, squared distance, stored minimum
    always_ff @(posedge clk) begin
        if (crd_rvalid) begin
            if (state == pcl_ctrl_pkg::CENTER) begin
                ctr_crd <= rdata;
            end else begin
                sq <= sq_dist(rdata, ctr_crd);
            end
        end
        if (dist_rvalid) begin
            old <= rdata[pcl_geom_pkg::DIST_WIDTH-1:0];
        end
    end

endmodule

// File: glb_arb.sv
// Round-robin buffer arbiter
`timescale 1ns/1ps

module glb_arb (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [pcl_ctrl_pkg::NUM_REQ-1:0]     req,
    input  logic [pcl_ctrl_pkg::NUM_REQ-1:0]     we,
    output logic [pcl_ctrl_pkg::NUM_REQ-1:0]     gnt,
    output logic [pcl_ctrl_pkg::NUM_REQ-1:0]     rvalid,
    input  pcl_ctrl_pkg::addr_t                  addr_host,
    input  pcl_ctrl_pkg::addr_t                  addr_crd,
    input  pcl_ctrl_pkg::addr_t                  addr_dist,
    input  logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   wdata_host,
    input  logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   wdata_dist,
    output logic                                 mem_en,
    output logic                                 mem_we,
    output pcl_ctrl_pkg::addr_t                  mem_addr,
    output logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   mem_wdata
);

    // Last granted requester, and the one picked this cycle
    pcl_ctrl_pkg::req_t last;
    pcl_ctrl_pkg::req_t sel;

    // ==================================================================
    // Rotating priority
    // ==================================================================
    // Scan from farthest to nearest after last, nearest hit wins
    always_comb begin
        int c;
        gnt = '0;
        sel = last;
        for (int i = pcl_ctrl_pkg::NUM_REQ; i >= 1; i--) begin
            c = (int'(last) + i) % pcl_ctrl_pkg::NUM_REQ;
            if (req[c]) begin
                gnt = '0;
                gnt[c] = 1'b1;
                sel = pcl_ctrl_pkg::req_t'(c);
            end
        end
    end

    // Winner's fields go straight to the buffer
    assign mem_en = |gnt;
    assign mem_we = |(gnt & we);
    assign mem_addr = (sel == pcl_ctrl_pkg::REQ_HOST) ? addr_host :
                      (sel == pcl_ctrl_pkg::REQ_CRD)  ? addr_crd : addr_dist;
    // Coordinate port is read-only
    assign mem_wdata = (sel == pcl_ctrl_pkg::REQ_HOST) ? wdata_host : wdata_dist;

    // Read data returns to its issuer one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last <= pcl_ctrl_pkg::req_t'(pcl_ctrl_pkg::NUM_REQ - 1);
            rvalid <= '0;
        end else begin
            if (mem_en) begin
                last <= sel;
            end
            rvalid <= gnt & ~we;
        end
    end

endmodule

// File: glb_sram.sv
// Global point buffer
`timescale 1ns/1ps

module glb_sram (
    input  logic                                 clk,
    input  logic                                 en,
    input  logic                                 we,
    input  pcl_ctrl_pkg::addr_t                  addr,
    input  logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   wdata,
    output logic [pcl_ctrl_pkg::MEM_WIDTH-1:0]   rdata
);

    // Coordinates in the low half, distance words in the high half
    logic [pcl_ctrl_pkg::MEM_WIDTH-1:0] mem [pcl_ctrl_pkg::MEM_DEPTH];

    // ==================================================================
    // Single port, write at the edge, registered read
    // ==================================================================
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                // Word shows up one cycle later
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: pcl_ctrl_pkg.sv
// Controller and buffer constants
package pcl_ctrl_pkg;

    // ==================================================================
    // Points and buffer layout
    // ==================================================================
    localparam int MAX_POINTS = 64;
    typedef logic [$clog2(MAX_POINTS)-1:0] idx_t;

    localparam int ADDR_WIDTH = 7;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;
    // Distance words sit above the coordinates
    localparam addr_t DIST_BASE = addr_t'(64);
    // Coordinate word, distance uses the low bits
    localparam int MEM_WIDTH = 48;

    // ==================================================================
    // Sorter and arbiter
    // ==================================================================
    localparam int MAX_K = 8;
    typedef logic [3:0] k_t;

    localparam int NUM_REQ = 3;
    typedef logic [$clog2(NUM_REQ)-1:0] req_t;
    localparam req_t REQ_HOST = req_t'(0);
    localparam req_t REQ_CRD = req_t'(1);
    localparam req_t REQ_DIST = req_t'(2);

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE, CENTER, LOOP, DRAIN, EMIT, FINISH
    } ctr_state_t;

endpackage

// File: pcl_geom_pkg.sv
// Point geometry types
package pcl_geom_pkg;

    // ==================================================================
    // Coordinates
    // ==================================================================

    // One unsigned component
    localparam int CRD_WIDTH = 16;
    // x, y, z
    localparam int CRD_DIM = 3;

    // Packed point, x in the low bits
    typedef logic [CRD_WIDTH*CRD_DIM-1:0] crd_t;

    // ==================================================================
    // Squared distances
    // ==================================================================

    // Three squared 16-bit differences fit in 34 bits
    localparam int DIST_WIDTH = 34;

    typedef logic [DIST_WIDTH-1:0] dist_t;

    // Stands in for a distance not yet known
    localparam dist_t DIST_MAX = '1;

endpackage
